// File: filelist.f
source/qlr_pkg.sv
source/qlr_rr_arbiter.sv
source/qlr_fifo.sv
source/qlr.sv
source/qlr_group.sv
verification/qlr_tb_clkgen.sv
verification/qlr_tb_checker.sv
verification/qlr_tb.sv

// File: Makefile
# Verilator build and run for the QLR group testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       := qlr_tb
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF -- "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/qlr_tb.sv
/* QLR group testbench
   Applies the operation table, models memory and bounds the run */
`default_nettype none

module qlr_tb import qlr_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned NumOps = 16;

  typedef enum logic [1:0] {
    OpBase,
    OpCount,
    OpLoad
  } op_e;

  // Base uses stride and bank, count uses count, load uses addr
  typedef struct packed {
    op_e        op;
    tag_t       tag;
    bank_addr_t stride;
    bank_addr_t bank;
    count_t     count;
    addr_t      addr;
  } op_t;

  logic        clk, rst_n;
  core_req_t   core_req;
  logic        core_req_valid, core_req_ready;
  mem_req_t    mem_req;
  logic        mem_req_valid, mem_req_ready;
  mem_rsp_t    mem_rsp;
  logic        mem_rsp_valid, mem_rsp_ready;
  core_rsp_t   core_rsp;
  logic        core_rsp_valid, core_rsp_ready;
  int unsigned rsp_count, check_count, error_count;

  op_t         ops [NumOps];
  int unsigned total_words = 0;  // Responses the table produces
  int unsigned cycle = 0;
  int unsigned cycle_limit = 0;
  mem_rsp_t    rsp_fifo [$];     // Accepted requests answered in order
  int unsigned due_fifo [$];

  qlr_tb_clkgen i_clkgen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  qlr_group uut (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .core_req_i       ( core_req       ),
    .core_req_valid_i ( core_req_valid ),
    .core_req_ready_o ( core_req_ready ),
    .mem_req_o        ( mem_req        ),
    .mem_req_valid_o  ( mem_req_valid  ),
    .mem_req_ready_i  ( mem_req_ready  ),
    .mem_rsp_i        ( mem_rsp        ),
    .mem_rsp_valid_i  ( mem_rsp_valid  ),
    .mem_rsp_ready_o  ( mem_rsp_ready  ),
    .core_rsp_o       ( core_rsp       ),
    .core_rsp_valid_o ( core_rsp_valid ),
    .core_rsp_ready_i ( core_rsp_ready )
  );

  qlr_tb_checker i_checker (
    .clk_i            ( clk            ),
    .rst_ni           ( rst_n          ),
    .core_req_i       ( core_req       ),
    .core_req_valid_i ( core_req_valid ),
    .core_req_ready_i ( core_req_ready ),
    .mem_req_i        ( mem_req        ),
    .mem_req_valid_i  ( mem_req_valid  ),
    .mem_req_ready_i  ( mem_req_ready  ),
    .mem_rsp_i        ( mem_rsp        ),
    .mem_rsp_valid_i  ( mem_rsp_valid  ),
    .mem_rsp_ready_i  ( mem_rsp_ready  ),
    .core_rsp_i       ( core_rsp       ),
    .core_rsp_valid_i ( core_rsp_valid ),
    .core_rsp_ready_i ( core_rsp_ready ),
    .rsp_count_o      ( rsp_count      ),
    .check_count_o    ( check_count    ),
    .error_count_o    ( error_count    )
  );

  // ----------------------------------------------------------------------
  // Memory model with random ready and two cycle latency
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    mem_rsp_t rsp;
    if (mem_rsp_valid && mem_rsp_ready) begin
      rsp_fifo.delete(0);
      due_fifo.delete(0);
    end
    if (mem_req_valid && mem_req_ready) begin
      rsp.data  = {2'b00, mem_req.addr[31:2]} ^ 32'h5A5A_0000;  // Word address key
      rsp.tag   = mem_req.tag;
      rsp.error = mem_req.addr[31];
      rsp.qlr   = mem_req.qlr;
      rsp_fifo.push_back(rsp);
      due_fifo.push_back(cycle + 2);
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      mem_req_ready  = ($urandom % 4) != 0;  // About 3 in 4 cycles ready
      core_rsp_ready = ($urandom % 4) != 0;
      if (rsp_fifo.size() != 0 && due_fifo[0] <= cycle) begin
        mem_rsp_valid = 1'b1;
        mem_rsp       = rsp_fifo[0];
      end else begin
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
      end
    end
  end

  // Cycle counter and run limit
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle_limit != 0 && cycle >= cycle_limit) begin
      $display("Timeout after %0d cycles with %0d of %0d responses seen",
               cycle, rsp_count, total_words);
      $display(">>> FAIL");
      $finish;
    end
  end

  // Present one request and hold it until the DUT takes it
  task automatic apply_op(input op_t op);
    core_req_t req;
    req = '0;
    case (op.op)
      OpBase: begin
        req.write = 1'b1;
        req.addr  = {22'h10_0000, op.tag, 3'd0, 2'b00};
        req.data  = {20'd0, op.stride, op.bank};
      end
      OpCount: begin                             // Starts the stream
        req.write = 1'b1;
        req.addr  = {22'h10_0000, op.tag, 3'd1, 2'b00};
        req.data  = {24'd0, op.count};
      end
      default: begin
        req.tag  = op.tag;
        req.addr = op.addr;
      end
    endcase
    core_req       = req;
    core_req_valid = 1'b1;
    @(posedge clk);
    while (!core_req_ready) @(posedge clk);
    @(negedge clk);
    core_req_valid = 1'b0;
    core_req       = '0;
  endtask

  initial begin
    int unsigned count_sum;
    count_sum      = 0;
    core_req       = '0;
    core_req_valid = 1'b0;
    mem_req_ready  = 1'b0;
    mem_rsp        = '0;
    mem_rsp_valid  = 1'b0;
    core_rsp_ready = 1'b0;
    void'($urandom(32'h9906_d5f4));

    ops[0]  = '{OpBase,  5'd18, 6'd1,  6'd0,  8'd0,  32'h0};
    ops[1]  = '{OpCount, 5'd18, 6'd0,  6'd0,  8'd6,  32'h0};
    ops[2]  = '{OpCount, 5'd18, 6'd0,  6'd0,  8'd5,  32'h0};  // Lands on a busy QLR
    ops[3]  = '{OpLoad,  5'd1,  6'd0,  6'd0,  8'd0,  32'h0000_0104};
    ops[4]  = '{OpLoad,  5'd2,  6'd0,  6'd0,  8'd0,  32'h8000_0200};  // Faults
    ops[5]  = '{OpLoad,  5'd3,  6'd0,  6'd0,  8'd0,  32'h0001_2FF8};
    ops[6]  = '{OpBase,  5'd19, 6'd3,  6'd5,  8'd0,  32'h0};
    ops[7]  = '{OpCount, 5'd19, 6'd0,  6'd0,  8'd10, 32'h0};
    ops[8]  = '{OpBase,  5'd20, 6'd7,  6'd60, 8'd0,  32'h0};  // Wraps bank space
    ops[9]  = '{OpCount, 5'd20, 6'd0,  6'd0,  8'd9,  32'h0};
    ops[10] = '{OpBase,  5'd21, 6'd2,  6'd17, 8'd0,  32'h0};
    ops[11] = '{OpCount, 5'd21, 6'd0,  6'd0,  8'd8,  32'h0};
    ops[12] = '{OpBase,  5'd18, 6'd13, 6'd33, 8'd0,  32'h0};
    ops[13] = '{OpCount, 5'd18, 6'd0,  6'd0,  8'd7,  32'h0};
    ops[14] = '{OpLoad,  5'd4,  6'd0,  6'd0,  8'd0,  32'h8000_1000};
    ops[15] = '{OpLoad,  5'd5,  6'd0,  6'd0,  8'd0,  32'h0000_0040};

    for (int i = 0; i < NumOps; i++) begin
      if (ops[i].op == OpCount) count_sum += 32'(ops[i].count);
      if (ops[i].op == OpLoad) total_words += 1;
    end
    total_words += count_sum;
    cycle_limit  = count_sum * 20 + 200;

    wait (rst_n);
    @(negedge clk);
    for (int i = 0; i < NumOps; i++) apply_op(ops[i]);

    while (rsp_count < total_words) @(posedge clk);
    repeat (10) @(posedge clk);  // Room for stray responses
    $display("Checks %0d, errors %0d, responses %0d of %0d",
             check_count, error_count, rsp_count, total_words);
    if (error_count == 0 && rsp_count == total_words) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/qlr_tb_checker.sv
/* QLR group response checker
   Tracks config and load requests, predicts each response and compares it */
`default_nettype none

module qlr_tb_checker import qlr_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  core_req_t   core_req_i,
  input  logic        core_req_valid_i,
  input  logic        core_req_ready_i,
  input  mem_req_t    mem_req_i,
  input  logic        mem_req_valid_i,
  input  logic        mem_req_ready_i,
  input  mem_rsp_t    mem_rsp_i,
  input  logic        mem_rsp_valid_i,
  input  logic        mem_rsp_ready_i,
  input  core_rsp_t   core_rsp_i,
  input  logic        core_rsp_valid_i,
  input  logic        core_rsp_ready_i,
  output int unsigned rsp_count_o,
  output int unsigned check_count_o,
  output int unsigned error_count_o
);

  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    tag_t  tag;
    data_t data;
    logic  error;
  } core_exp_t;

  bank_addr_t  base [NumQlrs];
  bank_addr_t  stride [NumQlrs];
  addr_t       exp_addr [NumQlrs][256];            // Predicted stream addresses
  int unsigned addr_wr [NumQlrs] = '{default: 0};
  int unsigned addr_rd [NumQlrs] = '{default: 0};  // Next request to match
  int unsigned rsp_rd [NumQlrs] = '{default: 0};   // Next response to match
  core_exp_t   core_exp [$];                       // Core loads in memory order
  logic        stall_q;
  mem_req_t    held_req;
  int unsigned rsp_count = 0;
  int unsigned checks = 0;
  int unsigned errors = 0;

  assign rsp_count_o   = rsp_count;
  assign check_count_o = checks;
  assign error_count_o = errors;

  // Tile ID above bit 10 and bank select at the word offset
  function automatic addr_t bank_to_addr(bank_addr_t b);
    addr_t a;
    a          = '0;
    a[10 +: 4] = b[5:2];
    a[2 +: 2]  = b[1:0];
    return a;
  endfunction

  function automatic data_t mem_word(addr_t a);
    return {2'b00, a[31:2]} ^ 32'h5A5A_0000;
  endfunction

  function automatic int qlr_index(tag_t tag);
    if (tag >= 5'd18 && tag <= 5'd21) return int'(tag) - 18;
    return -1;  // Not a QLR tag
  endfunction

  task automatic compare_field(input string name, input logic [31:0] exp,
                               input logic [31:0] got);
    checks++;
    if (exp !== got) begin
      errors++;
      $display("[ERROR] %0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic flag_problem(input string msg);
    checks++;
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  always @(posedge clk_i) begin
    int        idx;
    core_exp_t ce;
    if (!rst_ni) begin
      stall_q = 1'b0;
    end else begin
      // ------------------------------------------------------------------
      // Core response port
      // ------------------------------------------------------------------
      if (core_rsp_valid_i && core_rsp_ready_i) begin
        rsp_count++;
        idx = qlr_index(core_rsp_i.tag);
        if (idx >= 0) begin
          if (rsp_rd[idx] == addr_wr[idx]) begin
            flag_problem($sformatf("QLR tag %0d delivered an extra word", core_rsp_i.tag));
          end else begin
            compare_field("core_rsp_o.data", mem_word(exp_addr[idx][rsp_rd[idx] % 256]),
                          core_rsp_i.data);
            compare_field("core_rsp_o.error", 32'd0, 32'(core_rsp_i.error));
            rsp_rd[idx]++;
          end
        end else if (core_exp.size() == 0) begin
          flag_problem("core response arrived with no load outstanding");
        end else begin
          ce = core_exp.pop_front();
          compare_field("core_rsp_o.tag", 32'(ce.tag), 32'(core_rsp_i.tag));
          compare_field("core_rsp_o.data", ce.data, core_rsp_i.data);
          compare_field("core_rsp_o.error", 32'(ce.error), 32'(core_rsp_i.error));
        end
      end

      // ------------------------------------------------------------------
      // Memory response port
      // ------------------------------------------------------------------
      if (mem_rsp_valid_i) begin
        if (mem_rsp_i.qlr) begin  // Stream words are always taken
          compare_field("mem_rsp_ready_o", 32'd1, 32'(mem_rsp_ready_i));
        end else begin            // Core loads go straight to the core
          compare_field("core_rsp_valid_o", 32'd1, 32'(core_rsp_valid_i));
          compare_field("mem_rsp_ready_o", 32'(core_rsp_ready_i), 32'(mem_rsp_ready_i));
        end
      end

      // ------------------------------------------------------------------
      // Memory request port
      // ------------------------------------------------------------------
      if (stall_q) begin  // Held request must not move
        if (!mem_req_valid_i || (mem_req_i !== held_req))
          flag_problem("memory request changed or dropped before it was accepted");
        else
          checks++;
      end
      stall_q  = mem_req_valid_i && !mem_req_ready_i;
      held_req = mem_req_i;
      if (mem_req_valid_i && mem_req_ready_i) begin
        if (mem_req_i.qlr) begin
          idx = qlr_index(mem_req_i.tag);
          compare_field("mem_req_o.write", 32'd0, 32'(mem_req_i.write));
          compare_field("mem_req_o.size", 32'(SizeWord), 32'(mem_req_i.size));
          if (idx < 0) begin
            flag_problem("QLR memory request carries an unknown tag");
          end else if (addr_rd[idx] == addr_wr[idx]) begin
            flag_problem($sformatf("QLR tag %0d requested past its count", mem_req_i.tag));
          end else begin
            compare_field("mem_req_o.addr", exp_addr[idx][addr_rd[idx] % 256],
                          mem_req_i.addr);
            addr_rd[idx]++;
          end
        end else begin    // Pass-through keeps all fields
          compare_field("core_req_ready_o", 32'd1, 32'(core_req_valid_i && core_req_ready_i));
          compare_field("mem_req_o.tag", 32'(core_req_i.tag), 32'(mem_req_i.tag));
          compare_field("mem_req_o.addr", core_req_i.addr, mem_req_i.addr);
          compare_field("mem_req_o.data", core_req_i.data, mem_req_i.data);
          compare_field("mem_req_o.write", 32'(core_req_i.write), 32'(mem_req_i.write));
        end
      end

      // ------------------------------------------------------------------
      // Core request port
      // ------------------------------------------------------------------
      if (core_req_valid_i && core_req_ready_i) begin
        if (core_req_i.addr[31:10] == 22'h10_0000 && core_req_i.addr[1:0] == 2'b00) begin
          idx = qlr_index(core_req_i.addr[9:5]);
          if (idx < 0) begin
            flag_problem("config store accepted for an unknown tag");
          end else if (core_req_i.addr[4:2] == 3'd0) begin
            base[idx]   = core_req_i.data[5:0];
            stride[idx] = core_req_i.data[11:6];
          end else if (core_req_i.addr[4:2] == 3'd1) begin
            if (rsp_rd[idx] != addr_wr[idx])
              flag_problem("count write accepted while the QLR was still streaming");
            for (int unsigned k = 0; k < 32'(core_req_i.data[7:0]); k++) begin
              exp_addr[idx][addr_wr[idx] % 256] =
                bank_to_addr(bank_addr_t'(32'(base[idx]) + k * 32'(stride[idx])));
              addr_wr[idx]++;
            end
          end
        end else if (!core_req_i.write) begin
          ce.tag   = core_req_i.tag;
          ce.data  = mem_word(core_req_i.addr);
          ce.error = core_req_i.addr[31];  // Upper half of the map faults
          core_exp.push_back(ce);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/qlr_tb_clkgen.sv
/* Testbench clock and reset
   8 ns clock, reset held low for the first 8 cycles */
`default_nettype none

module qlr_tb_clkgen (
  output logic clk_o,
  output logic rst_no
);

  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    clk_o = 1'b0;
    forever #4 clk_o = ~clk_o;  // 8 ns period
  end

  initial begin
    rst_no = 1'b0;
    repeat (8) @(posedge clk_o);
    @(negedge clk_o);           // Release away from the active edge
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

// File: source/qlr_group.sv
/* QLR group
   Hosts the QLRs, decodes config stores and shares the memory and core ports */
`default_nettype none

module qlr_group import qlr_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // Core request
  input  core_req_t core_req_i,
  input  logic      core_req_valid_i,
  output logic      core_req_ready_o,
  // Memory request
  output mem_req_t  mem_req_o,
  output logic      mem_req_valid_o,
  input  logic      mem_req_ready_i,
  // Memory response
  input  mem_rsp_t  mem_rsp_i,
  input  logic      mem_rsp_valid_i,
  output logic      mem_rsp_ready_o,
  // Core response
  output core_rsp_t core_rsp_o,
  output logic      core_rsp_valid_o,
  input  logic      core_rsp_ready_i
);

  qlr_req_t [NumQlrs-1:0] qlr_req;
  logic     [NumQlrs-1:0] qlr_req_valid, qlr_req_gnt;
  qlr_rsp_t [NumQlrs-1:0] qlr_rsp;
  logic     [NumQlrs-1:0] qlr_rsp_valid, qlr_rsp_gnt;
  logic                   qlr_mem_rsp_valid;

  qlr_cfg_word_u          cfg_data;
  tag_t                   cfg_tag;
  logic [2:0]             cfg_reg;
  logic                   cfg_match, cfg_valid;
  logic     [NumQlrs-1:0] cfg_ready;
  logic     [NumQlrs-1:0] cfg_tag_hit;  // Tag belongs to some QLR

  qlr_req_t               arb_req;
  logic                   arb_req_valid, arb_req_gnt;
  addr_t                  arb_req_addr;
  logic                   qlr_select;   // QLR side owns the memory request port
  logic                   lock_q;
  qlr_rsp_t               arb_rsp;
  logic                   arb_rsp_valid, arb_rsp_gnt;
  logic                   qlr_rsp_select;

  // ----------------------------------------------------------------------
  // QLR instances
  // ----------------------------------------------------------------------
  for (genvar ii = 0; ii < NumQlrs; ii++) begin : gen_qlrs
    qlr #(
      .AssignedTag ( QlrTags[ii] )
    ) i_qlr (
      .clk_i,
      .rst_ni,
      .cfg_data_i      ( cfg_data          ),
      .cfg_tag_i       ( cfg_tag           ),
      .cfg_reg_i       ( cfg_reg           ),
      .cfg_valid_i     ( cfg_valid         ),
      .cfg_ready_o     ( cfg_ready[ii]     ),
      .req_o           ( qlr_req[ii]       ),
      .req_valid_o     ( qlr_req_valid[ii] ),
      .req_gnt_i       ( qlr_req_gnt[ii]   ),
      .mem_rsp_i,
      .mem_rsp_valid_i ( qlr_mem_rsp_valid ),
      .rsp_o           ( qlr_rsp[ii]       ),
      .rsp_valid_o     ( qlr_rsp_valid[ii] ),
      .rsp_gnt_i       ( qlr_rsp_gnt[ii]   )
    );
    assign cfg_tag_hit[ii] = (cfg_tag == QlrTags[ii]);
  end

  assign qlr_mem_rsp_valid = mem_rsp_valid_i & mem_rsp_i.qlr;

  // Config stores are caught by address and never reach memory
  assign cfg_match = (core_req_i.addr ==? QlrCfgMask);
  assign cfg_valid = core_req_valid_i & cfg_match;
  assign cfg_tag   = core_req_i.addr[5 +: TagWidth];
  assign cfg_reg   = core_req_i.addr[2 +: 3];
  assign cfg_data  = core_req_i.data;

  // ----------------------------------------------------------------------
  // Memory request sharing
  // ----------------------------------------------------------------------
  qlr_rr_arbiter #(
    .NumIn  ( NumQlrs   ),
    .data_t ( qlr_req_t )
  ) i_req_arb (
    .clk_i,
    .rst_ni,
    .req_i  ( qlr_req_valid ),
    .gnt_o  ( qlr_req_gnt   ),
    .data_i ( qlr_req       ),
    .req_o  ( arb_req_valid ),
    .gnt_i  ( arb_req_gnt   ),
    .data_o ( arb_req       )
  );

  // Tile ID above the sequential region, bank select as word offset
  always_comb begin
    arb_req_addr                             = '0;
    arb_req_addr[SeqAddrBits +: TileSelBits] = arb_req.bank_addr[BankAddrWidth-1:BankSelBits];
    arb_req_addr[2 +: BankSelBits]           = arb_req.bank_addr[BankSelBits-1:0];
  end

  assign qlr_select  = !(core_req_valid_i && !cfg_match) || lock_q;
  assign arb_req_gnt = arb_req_valid & mem_req_ready_i & qlr_select;

  always_comb begin
    if (qlr_select) begin
      mem_req_o       = '{tag: arb_req.tag, write: 1'b0, addr: arb_req_addr,
                          data: '0, size: SizeWord, qlr: 1'b1};
      mem_req_valid_o = arb_req_valid;
    end else begin
      mem_req_o       = '{tag: core_req_i.tag, write: core_req_i.write, addr: core_req_i.addr,
                          data: core_req_i.data, size: SizeWord, qlr: 1'b0};
      mem_req_valid_o = core_req_valid_i;
    end
  end

  // Config waits for every QLR, a lock keeps the core out
  assign core_req_ready_o = qlr_select ? (cfg_valid & (&cfg_ready)) : mem_req_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) lock_q <= 1'b0;
    else lock_q <= qlr_select & arb_req_valid & ~mem_req_ready_i;  // Presented, not taken
  end

  // ----------------------------------------------------------------------
  // Core response sharing
  // ----------------------------------------------------------------------
  qlr_rr_arbiter #(
    .NumIn  ( NumQlrs   ),
    .data_t ( qlr_rsp_t )
  ) i_rsp_arb (
    .clk_i,
    .rst_ni,
    .req_i  ( qlr_rsp_valid ),
    .gnt_o  ( qlr_rsp_gnt   ),
    .data_i ( qlr_rsp       ),
    .req_o  ( arb_rsp_valid ),
    .gnt_i  ( arb_rsp_gnt   ),
    .data_o ( arb_rsp       )
  );

  assign qlr_rsp_select = !(mem_rsp_valid_i && !mem_rsp_i.qlr);  // Core loads first
  assign arb_rsp_gnt    = arb_rsp_valid & core_rsp_ready_i & qlr_rsp_select;

  assign core_rsp_o = qlr_rsp_select ?
                      '{data: arb_rsp.data, tag: arb_rsp.tag, error: 1'b0} :
                      '{data: mem_rsp_i.data, tag: mem_rsp_i.tag, error: mem_rsp_i.error};
  assign core_rsp_valid_o = qlr_rsp_select ? arb_rsp_valid : mem_rsp_valid_i;

  // QLR responses always land in a FIFO slot claimed by credit
  assign mem_rsp_ready_o = qlr_rsp_select ? mem_rsp_valid_i : core_rsp_ready_i;

  a_cfg_tag_known : assert property (@(posedge clk_i) disable iff (!rst_ni)
    cfg_valid |-> (|cfg_tag_hit)) else $error("Config targets an unknown QLR tag");

endmodule

`default_nettype wire

// File: source/qlr.sv
/* Queue linked register
   Streams word loads from strided bank addresses into a credited FIFO */
`default_nettype none

module qlr import qlr_pkg::*; #(
  parameter tag_t AssignedTag = QlrTags[0]
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  // Config broadcast from the group
  input  qlr_cfg_word_u cfg_data_i,
  input  tag_t          cfg_tag_i,
  input  logic [2:0]    cfg_reg_i,
  input  logic          cfg_valid_i,
  output logic          cfg_ready_o,
  // Stream requests to the arbiter
  output qlr_req_t      req_o,
  output logic          req_valid_o,
  input  logic          req_gnt_i,
  // Memory responses, seen by every QLR
  input  mem_rsp_t      mem_rsp_i,
  input  logic          mem_rsp_valid_i,
  // Buffered words to the core
  output qlr_rsp_t      rsp_o,
  output logic          rsp_valid_o,
  input  logic          rsp_gnt_i
);

  bank_addr_t             base_q, stride_q;
  bank_addr_t             addr_q;      // Next bank address to request
  count_t                 req_left_q;  // Requests still to issue
  count_t                 rsp_left_q;  // Words still to deliver
  logic [CreditWidth-1:0] credit_q;    // Free FIFO slots not yet claimed
  logic                   busy, cfg_hit, cfg_we;
  logic                   rsp_push, fifo_empty, fifo_full;
  data_t                  fifo_data;

  // ----------------------------------------------------------------------
  // Configuration
  // ----------------------------------------------------------------------
  assign busy        = (rsp_left_q != '0);
  assign cfg_hit     = (cfg_tag_i == AssignedTag);
  assign cfg_ready_o = !cfg_hit || !busy;  // Hold off only our own config
  assign cfg_we      = cfg_valid_i && cfg_hit && !busy;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      base_q   <= '0;
      stride_q <= '0;
    end else if (cfg_we && (cfg_reg_i == CfgRegBase)) begin
      base_q   <= cfg_data_i.base.bank_addr;
      stride_q <= cfg_data_i.base.stride;
    end
  end

  // ----------------------------------------------------------------------
  // Request generator
  // ----------------------------------------------------------------------
  assign req_valid_o = (req_left_q != '0) && (credit_q != '0);
  assign req_o       = '{bank_addr: addr_q, tag: AssignedTag};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q     <= '0;
      req_left_q <= '0;
      rsp_left_q <= '0;
    end else if (cfg_we && (cfg_reg_i == CfgRegCount)) begin
      addr_q     <= base_q;                   // Stream restarts at base
      req_left_q <= cfg_data_i.count.count;
      rsp_left_q <= cfg_data_i.count.count;
    end else begin
      if (req_gnt_i) begin
        addr_q     <= addr_q + stride_q;      // Wraps within the bank space
        req_left_q <= req_left_q - 1'b1;
      end
      if (rsp_gnt_i) rsp_left_q <= rsp_left_q - 1'b1;
    end
  end

  // Claim a slot per request, free it per delivered word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) credit_q <= CreditWidth'(QlrFifoDepth);
    else credit_q <= credit_q - CreditWidth'(req_gnt_i) + CreditWidth'(rsp_gnt_i);
  end

  // ----------------------------------------------------------------------
  // Response buffer
  // ----------------------------------------------------------------------
  assign rsp_push = mem_rsp_valid_i && (mem_rsp_i.tag == AssignedTag);

  qlr_fifo #(
    .Depth ( QlrFifoDepth )
  ) i_fifo (
    .clk_i,
    .rst_ni,
    .push_i  ( rsp_push       ),
    .data_i  ( mem_rsp_i.data ),
    .pop_i   ( rsp_gnt_i      ),
    .data_o  ( fifo_data      ),
    .empty_o ( fifo_empty     ),
    .full_o  ( fifo_full      )
  );

  assign rsp_valid_o = !fifo_empty;
  assign rsp_o       = '{data: fifo_data, tag: AssignedTag};

  a_credit_max : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CreditWidth'(QlrFifoDepth)) else $error("Credits above FIFO depth");
  // A full FIFO leaves nothing to claim
  a_full_no_credit : assert property (@(posedge clk_i) disable iff (!rst_ni)
    fifo_full |-> (credit_q == '0)) else $error("Credits left with full FIFO");

endmodule

`default_nettype wire

// File: source/qlr_fifo.sv
/* Stream word FIFO
   Circular buffer for words returned from memory to one QLR */
`default_nettype none

module qlr_fifo import qlr_pkg::*; #(
  parameter int unsigned Depth = QlrFifoDepth
) (
  input  logic  clk_i,
  input  logic  rst_ni,
  input  logic  push_i,
  input  data_t data_i,
  input  logic  pop_i,
  output data_t data_o,
  output logic  empty_o,
  output logic  full_o
);

  localparam int unsigned PtrWidth  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned FillWidth = $clog2(Depth + 1);

  data_t                mem_q [Depth];
  logic [PtrWidth-1:0]  wr_ptr_q, rd_ptr_q;
  logic [FillWidth-1:0] fill_q;

  assign empty_o = (fill_q == '0);
  assign full_o  = (fill_q == FillWidth'(Depth));
  assign data_o  = mem_q[rd_ptr_q];  // Head word

  always_ff @(posedge clk_i) begin
    if (push_i) mem_q[wr_ptr_q] <= data_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push_i) wr_ptr_q <= (wr_ptr_q == PtrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (pop_i)  rd_ptr_q <= (rd_ptr_q == PtrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      fill_q <= fill_q + FillWidth'(push_i) - FillWidth'(pop_i);
    end
  end

  a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o) else $error("Push into full FIFO");
  a_no_underflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o) else $error("Pop from empty FIFO");

endmodule

`default_nettype wire

// File: source/qlr_rr_arbiter.sv
/* Round-robin arbiter with lock-in
   Picks one requester and forwards its payload, holds the pick until granted */
`default_nettype none

module qlr_rr_arbiter #(
  parameter int unsigned NumIn  = 4,
  parameter type         data_t = logic [31:0]
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic  [NumIn-1:0]    req_i,
  output logic  [NumIn-1:0]    gnt_o,
  input  data_t [NumIn-1:0]    data_i,
  output logic                 req_o,
  input  logic                 gnt_i,
  output data_t                data_o
);

  localparam int unsigned IdxWidth = (NumIn > 1) ? $clog2(NumIn) : 1;

  logic [IdxWidth-1:0] prio_q;      // Highest priority input
  logic [IdxWidth-1:0] pick;
  logic [IdxWidth-1:0] sel_idx;
  logic [IdxWidth-1:0] lock_idx_q;
  logic                lock_q;      // Pending request not yet granted

  // Search from farthest to nearest, so the nearest requester wins
  always_comb begin
    int unsigned cand;
    pick = prio_q;
    for (int unsigned i = 0; i < NumIn; i++) begin
      cand = (prio_q + NumIn - 1 - i) % NumIn;
      if (req_i[cand]) pick = IdxWidth'(cand);
    end
  end

  assign sel_idx = lock_q ? lock_idx_q : pick;
  assign req_o   = req_i[sel_idx];
  assign data_o  = data_i[sel_idx];

  always_comb begin
    gnt_o          = '0;
    gnt_o[sel_idx] = gnt_i;  // Only the selected input sees the grant
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prio_q     <= '0;
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else if (req_o && gnt_i) begin
      prio_q <= (sel_idx == IdxWidth'(NumIn - 1)) ? '0 : sel_idx + 1'b1;  // Rotate
      lock_q <= 1'b0;
    end else if (req_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel_idx;
    end
  end

  // Requester and arbiter together keep an ungranted request steady
  a_locked_stable : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (req_o && !gnt_i) |=> (req_o && $stable(data_o)))
    else $error("Arbiter output changed before grant");

endmodule

`default_nettype wire

// File: source/qlr_pkg.sv
/* QLR package
   Widths, register tags, the config window and the bus structs of the QLR group */
`default_nettype none

package qlr_pkg;

  // ----------------------------------------------------------------------
  // Widths and sizes
  // ----------------------------------------------------------------------
  localparam int unsigned DataWidth     = 32;
  localparam int unsigned AddrWidth     = 32;
  localparam int unsigned TagWidth      = 5;
  localparam int unsigned NumQlrs       = 4;
  localparam int unsigned BankAddrWidth = 6;   // Tile ID and local bank select
  localparam int unsigned BankSelBits   = 2;   // Banks per tile
  localparam int unsigned SeqAddrBits   = 10;  // Sequential region per tile
  localparam int unsigned TileSelBits   = BankAddrWidth - BankSelBits;
  localparam int unsigned QlrFifoDepth  = 4;   // Also the initial credit count
  localparam int unsigned CountWidth    = 8;
  localparam int unsigned CreditWidth   = $clog2(QlrFifoDepth + 1);

  // ----------------------------------------------------------------------
  // Scalar types
  // ----------------------------------------------------------------------
  typedef logic [TagWidth-1:0]      tag_t;
  typedef logic [DataWidth-1:0]     data_t;
  typedef logic [AddrWidth-1:0]     addr_t;
  typedef logic [BankAddrWidth-1:0] bank_addr_t;
  typedef logic [CountWidth-1:0]    count_t;

  typedef enum logic [1:0] {
    SizeByte = 2'b00,
    SizeHalf = 2'b01,
    SizeWord = 2'b10
  } size_e;

  // Register tags owned by the QLRs, index 0 is the first instance
  localparam tag_t [NumQlrs-1:0] QlrTags = {5'd21, 5'd20, 5'd19, 5'd18};

  // Config window, tag in bits 5 and up, register index in bits 2 to 4
  localparam addr_t QlrCfgMask = {22'h10_0000, 8'bxxxx_xxxx, 2'b00};

  localparam logic [2:0] CfgRegBase  = 3'd0;  // Stride and base bank address
  localparam logic [2:0] CfgRegCount = 3'd1;  // Element count, starts the stream

  // ----------------------------------------------------------------------
  // Port structs
  // ----------------------------------------------------------------------
  typedef struct packed {
    tag_t  tag;
    logic  write;
    addr_t addr;
    data_t data;
  } core_req_t;

  typedef struct packed {
    data_t data;
    tag_t  tag;
    logic  error;
  } core_rsp_t;

  typedef struct packed {
    tag_t  tag;
    logic  write;
    addr_t addr;
    data_t data;
    size_e size;
    logic  qlr;  // Issued by a QLR
  } mem_req_t;

  typedef struct packed {
    data_t data;
    tag_t  tag;
    logic  error;
    logic  qlr;
  } mem_rsp_t;

  typedef struct packed {
    bank_addr_t bank_addr;
    tag_t       tag;
  } qlr_req_t;

  typedef struct packed {
    data_t data;
    tag_t  tag;
  } qlr_rsp_t;

  // Config word, two views picked by the register index
  typedef struct packed {
    logic [DataWidth-2*BankAddrWidth-1:0] rsvd;
    bank_addr_t                           stride;
    bank_addr_t                           bank_addr;
  } qlr_cfg_base_t;

  typedef struct packed {
    logic [DataWidth-CountWidth-1:0] rsvd;
    count_t                          count;
  } qlr_cfg_count_t;

  typedef union packed {
    qlr_cfg_base_t  base;
    qlr_cfg_count_t count;
  } qlr_cfg_word_u;

endpackage

`default_nettype wire
